// ==== hdl/pod_pkg.sv ====
package pod_pkg;

	////////////////////////////////////////
	// Pod geometry

	// Lanes per pod
	localparam int num_lanes = 8;

	// Deserialized samples per leg per clock
	localparam int samples_per_leg = 8;

	// Board pin feeding each front panel lane
	// Index is the front lane, value is the board pin
	localparam int lane_pin_map [num_lanes] = '{3, 2, 7, 6, 5, 4, 1, 0};

	////////////////////////////////////////
	// Widths with a meaning

	// One leg of one lane for one clock
	typedef logic [samples_per_leg-1:0] leg_t;

	// Both legs of one lane interleaved
	typedef logic [2*samples_per_leg-1:0] sample_word_t;

	// One bit per lane
	typedef logic [num_lanes-1:0] lane_mask_t;

	// Overflow event count
	typedef logic [31:0] ovf_count_t;

	////////////////////////////////////////
	// Bundles

	// Raw legs straight off the deserializers, board pin order
	typedef struct packed {
		leg_t [num_lanes-1:0] pos;
		leg_t [num_lanes-1:0] neg;
	} pod_legs_t;

	// Merged words, front panel order
	typedef struct packed {
		sample_word_t [num_lanes-1:0] words;
	} sample_bus_t;

	// What leaves the capture stage each clock
	typedef struct packed {
		logic        valid;
		sample_bus_t samples;
		lane_mask_t  overflow;
	} capture_out_t;

	// Per lane overflow totals for the last interval
	typedef struct packed {
		ovf_count_t [num_lanes-1:0] count;
	} ovf_snapshot_t;

endpackage

// ==== hdl/sample_merge.sv ====
`timescale 1ns/10ps

module sample_merge #(
	// Invert mask indexed by board pin
	parameter pod_pkg::lane_mask_t lane_invert = '0
) (
	input  logic                clk_312p5mhz,
	input  pod_pkg::pod_legs_t  pod_legs,
	output pod_pkg::sample_bus_t samples
);

	////////////////////////////////////////
	// Board pin to front panel remap

	// Legs after remap
	pod_pkg::leg_t [pod_pkg::num_lanes-1:0] front_pos;
	pod_pkg::leg_t [pod_pkg::num_lanes-1:0] front_neg;

	// Invert mask moved into front lane order
	pod_pkg::lane_mask_t front_invert;

	for (genvar k = 0; k < pod_pkg::num_lanes; k++) begin : g_remap
		// Pin that drives this front lane
		localparam int pin = pod_pkg::lane_pin_map[k];

		assign front_pos[k]    = pod_legs.pos[pin];
		assign front_neg[k]    = pod_legs.neg[pin];

		// The invert bit follows its pin
		assign front_invert[k] = lane_invert[pin];
	end

	////////////////////////////////////////
	// Leg interleave

	// Combinational merged words ahead of the register
	pod_pkg::sample_bus_t merged;

	// N leg has the longer input delay
	// so its sample is the earlier one of each pair
	// and lands on the odd bit
	always_comb begin
		for (int k = 0; k < pod_pkg::num_lanes; k++) begin
			for (int i = 0; i < pod_pkg::samples_per_leg; i++) begin
				// N leg arrives complemented from the LVDS pair
				merged.words[k][2*i+1] = ~front_neg[k][i] ^ front_invert[k];
				merged.words[k][2*i]   = front_pos[k][i] ^ front_invert[k];
			end
		end
	end

	////////////////////////////////////////
	// Output register

	// Single pipeline stage
	always_ff @(posedge clk_312p5mhz) begin
		samples <= merged;
	end

endmodule

// ==== hdl/overflow_counter.sv ====
`timescale 1ns/10ps

module overflow_counter #(
	// Clocks per measurement interval
	parameter int unsigned interval_cycles = 312500000
) (
	input  logic                   clk_312p5mhz,
	input  logic                   trig_rst,
	input  pod_pkg::lane_mask_t    lane_overflow,
	output logic                   interval_tick,
	output pod_pkg::lane_mask_t    active_mask,
	output pod_pkg::ovf_snapshot_t snapshot
);

	////////////////////////////////////////
	// Interval timer

	// Wide enough for interval_cycles - 1
	localparam int timer_bits = (interval_cycles > 1) ? $clog2(interval_cycles) : 1;

	// Terminal count
	localparam logic [timer_bits-1:0] timer_last = timer_bits'(interval_cycles - 1);

	logic [timer_bits-1:0] timer;

	// Tick is registered on the terminal count
	// and lasts one clock
	always_ff @(posedge clk_312p5mhz) begin
		if (trig_rst) begin
			timer         <= '0;
			interval_tick <= 1'b0;
		end else if (timer == timer_last) begin
			timer         <= '0;
			interval_tick <= 1'b1;
		end else begin
			timer         <= timer + 1'b1;
			interval_tick <= 1'b0;
		end
	end

	////////////////////////////////////////
	// Per lane counters

	// Events seen so far in this interval
	pod_pkg::ovf_count_t [pod_pkg::num_lanes-1:0] running;

	// Tick copies the running counts out and restarts them
	// A pulse landing on the tick edge is dropped
	always_ff @(posedge clk_312p5mhz) begin
		if (trig_rst) begin
			running  <= '0;
			snapshot <= '0;
		end else if (interval_tick) begin
			snapshot.count <= running;
			running        <= '0;
		end else begin
			for (int k = 0; k < pod_pkg::num_lanes; k++) begin
				if (lane_overflow[k]) begin
					running[k] <= running[k] + 1'b1;
				end
			end
		end
	end

	// Lanes that overflowed in the current interval
	always_comb begin
		for (int k = 0; k < pod_pkg::num_lanes; k++) begin
			active_mask[k] = |running[k];
		end
	end

	////////////////////////////////////////
	// Checks

	// Tick is a single clock strobe
	a_tick_single: assert property (
		@(posedge clk_312p5mhz) disable iff (trig_rst)
		interval_tick |=> !interval_tick
	) else $error("interval_tick held for more than one clock");

	// A nonzero count only returns to zero through a tick or reset
	for (genvar k = 0; k < pod_pkg::num_lanes; k++) begin : g_wrap_chk
		a_no_wrap: assert property (
			@(posedge clk_312p5mhz) disable iff (trig_rst)
			(running[k] != '0 && !interval_tick) |=> (running[k] != '0)
		) else $error("overflow counter wrapped on lane %0d", k);
	end

endmodule

// ==== hdl/pod_capture.sv ====
`timescale 1ns/10ps

module pod_capture (
	input  logic                  clk_312p5mhz,
	input  logic                  trig_rst,
	input  logic                  capture_en,
	input  pod_pkg::sample_bus_t  samples,
	input  pod_pkg::lane_mask_t   active_mask,
	input  pod_pkg::lane_mask_t   flush_done,
	output pod_pkg::capture_out_t capture_out,
	output logic                  flush_complete
);

	////////////////////////////////////////
	// Capture output stage

	// Qualifier and overflow tag
	logic                valid_q;
	pod_pkg::lane_mask_t overflow_q;

	// Sample words, no reset needed on data
	pod_pkg::sample_bus_t samples_q;

	// Enable qualifies the words of the same clock
	always_ff @(posedge clk_312p5mhz) begin
		if (trig_rst) begin
			valid_q    <= 1'b0;
			overflow_q <= '0;
		end else begin
			valid_q    <= capture_en;
			overflow_q <= active_mask;
		end
	end

	// Data stage runs every clock
	always_ff @(posedge clk_312p5mhz) begin
		samples_q <= samples;
	end

	// Pack the output bundle
	assign capture_out = '{
		valid:    valid_q,
		samples:  samples_q,
		overflow: overflow_q
	};

	////////////////////////////////////////
	// Flush tracking

	// Lanes that have reported flush done since reset
	pod_pkg::lane_mask_t flushed;

	// Sticky until reset
	always_ff @(posedge clk_312p5mhz) begin
		if (trig_rst) begin
			flushed <= '0;
		end else begin
			flushed <= flushed | flush_done;
		end
	end

	// All lanes in, registered once more
	always_ff @(posedge clk_312p5mhz) begin
		if (trig_rst) begin
			flush_complete <= 1'b0;
		end else begin
			flush_complete <= &flushed;
		end
	end

	////////////////////////////////////////
	// Checks

	// Completion only clears through reset
	a_flush_sticky: assert property (
		@(posedge clk_312p5mhz)
		(flush_complete && !trig_rst) |=> flush_complete
	) else $error("flush_complete dropped without trig_rst");

endmodule

// ==== hdl/pod_datapath.sv ====
`timescale 1ns/10ps

module pod_datapath #(
	// Per pin inversion, board pin order
	parameter pod_pkg::lane_mask_t lane_invert = '0,

	// Overflow measurement interval in clocks
	parameter int unsigned interval_cycles = 312500000
) (
	input  logic                   clk_312p5mhz,
	input  logic                   trig_rst,
	input  logic                   capture_en,
	input  pod_pkg::pod_legs_t     pod_legs,
	input  pod_pkg::lane_mask_t    lane_overflow,
	input  pod_pkg::lane_mask_t    flush_done,
	output pod_pkg::capture_out_t  capture_out,
	output logic                   flush_complete,
	output logic                   interval_tick,
	output pod_pkg::ovf_snapshot_t ovf_snapshot
);

	////////////////////////////////////////
	// Internal links

	// Merged words, front panel order
	pod_pkg::sample_bus_t merged_samples;

	// Lanes with overflows in the current interval
	pod_pkg::lane_mask_t  active_mask;

	////////////////////////////////////////
	// Sample path

	sample_merge #(
		.lane_invert(lane_invert)
	) merge (
		.clk_312p5mhz (clk_312p5mhz),
		.pod_legs     (pod_legs),
		.samples      (merged_samples)
	);

	////////////////////////////////////////
	// Overflow statistics

	overflow_counter #(
		.interval_cycles(interval_cycles)
	) ovf (
		.clk_312p5mhz  (clk_312p5mhz),
		.trig_rst      (trig_rst),
		.lane_overflow (lane_overflow),
		.interval_tick (interval_tick),
		.active_mask   (active_mask),
		.snapshot      (ovf_snapshot)
	);

	////////////////////////////////////////
	// Combine and flush status

	pod_capture capture (
		.clk_312p5mhz   (clk_312p5mhz),
		.trig_rst       (trig_rst),
		.capture_en     (capture_en),
		.samples        (merged_samples),
		.active_mask    (active_mask),
		.flush_done     (flush_done),
		.capture_out    (capture_out),
		.flush_complete (flush_complete)
	);

endmodule

// ==== bench/pod_clock_gen.sv ====
`timescale 1ns/10ps

module pod_clock_gen #(
	// Clock edges with reset held high
	parameter int reset_cycles = 3
) (
	output logic clk_312p5mhz,
	output logic rst
);

	// Half of the 200 ns bench period
	localparam int half_period_ns = 100;

	// Free running clock
	initial begin
		clk_312p5mhz = 1'b0;
		forever #half_period_ns clk_312p5mhz = ~clk_312p5mhz;
	end

	// Power-on reset, released on a rising edge
	initial begin
		rst = 1'b1;
		repeat (reset_cycles) @(posedge clk_312p5mhz);
		rst <= 1'b0;
	end

endmodule

// ==== bench/pod_datapath_tb.sv ====
`timescale 1ns/10ps

module pod_datapath_tb;

	////////////////////////////////////////
	// Bench setup

	// Nonzero invert pattern, board pin order
	localparam pod_pkg::lane_mask_t tb_lane_invert = 8'b1010_0110;
	localparam int unsigned tb_interval = 64;
	localparam int clk_period_ns = 200;

	// Nominal test lengths in clocks
	localparam int len_remap = 40;
	localparam int len_gating = 60;
	localparam int len_snapshot = 3 * tb_interval;
	localparam int len_mask = 200;
	localparam int len_flush = 40;
	localparam int len_reset = 160;
	localparam int watchdog_cycles =
		2 * (3 + len_remap + len_gating + len_snapshot + len_mask + len_flush + len_reset);

	logic                   clk_312p5mhz;
	logic                   por_rst;
	logic                   tb_rst = 1'b0;
	logic                   trig_rst;
	logic                   capture_en;
	pod_pkg::pod_legs_t     pod_legs;
	pod_pkg::lane_mask_t    lane_overflow;
	pod_pkg::lane_mask_t    flush_done;
	pod_pkg::capture_out_t  capture_out;
	logic                   flush_complete;
	logic                   interval_tick;
	pod_pkg::ovf_snapshot_t ovf_snapshot;

	int          error_count = 0;
	int          check_count = 0;
	int unsigned rng_seed = 15477;
	int unsigned first_draw;

	// Power-on reset or a mid-run reset from the stimulus
	assign trig_rst = por_rst | tb_rst;

	pod_clock_gen #(.reset_cycles(3)) clock_gen (
		.clk_312p5mhz (clk_312p5mhz),
		.rst          (por_rst)
	);

	pod_datapath #(
		.lane_invert     (tb_lane_invert),
		.interval_cycles (tb_interval)
	) uut (
		.clk_312p5mhz   (clk_312p5mhz),
		.trig_rst       (trig_rst),
		.capture_en     (capture_en),
		.pod_legs       (pod_legs),
		.lane_overflow  (lane_overflow),
		.flush_done     (flush_done),
		.capture_out    (capture_out),
		.flush_complete (flush_complete),
		.interval_tick  (interval_tick),
		.ovf_snapshot   (ovf_snapshot)
	);

	////////////////////////////////////////
	// Reference model

	// Front lane k takes pin map[k], N leg complemented onto odd bits
	function automatic pod_pkg::sample_bus_t merge_ref(input pod_pkg::pod_legs_t legs,
			input pod_pkg::lane_mask_t invert);
		pod_pkg::sample_bus_t bus;
		int pin;
		for (int k = 0; k < pod_pkg::num_lanes; k++) begin
			pin = pod_pkg::lane_pin_map[k];
			for (int i = 0; i < pod_pkg::samples_per_leg; i++) begin
				bus.words[k][2*i+1] = ~legs.neg[pin][i] ^ invert[pin];
				bus.words[k][2*i]   = legs.pos[pin][i] ^ invert[pin];
			end
		end
		return bus;
	endfunction

	// Lanes with a nonzero count
	function automatic pod_pkg::lane_mask_t nonzero_lanes(input pod_pkg::ovf_snapshot_t counts);
		pod_pkg::lane_mask_t mask;
		for (int k = 0; k < pod_pkg::num_lanes; k++) begin
			mask[k] = (counts.count[k] != 0);
		end
		return mask;
	endfunction

	pod_pkg::sample_bus_t   m_stage;
	pod_pkg::capture_out_t  m_capture;
	pod_pkg::ovf_snapshot_t m_running;
	pod_pkg::ovf_snapshot_t m_snap;
	pod_pkg::lane_mask_t    m_flushed;
	logic                   m_flush_complete;
	logic                   m_tick;
	int unsigned            m_timer;

	// Cycle model, all state moves on the edge like the DUT
	always @(posedge clk_312p5mhz) begin
		m_stage           <= merge_ref(pod_legs, tb_lane_invert);
		m_capture.samples <= m_stage;
		if (trig_rst) begin
			m_capture.valid    <= 1'b0;
			m_capture.overflow <= '0;
			m_timer            <= 0;
			m_tick             <= 1'b0;
			m_running          <= '0;
			m_snap             <= '0;
			m_flushed          <= '0;
			m_flush_complete   <= 1'b0;
		end else begin
			m_capture.valid    <= capture_en;
			m_capture.overflow <= nonzero_lanes(m_running);
			// Tick goes out interval clocks after the last reset clock
			if (m_timer == tb_interval - 1) begin
				m_timer <= 0;
				m_tick  <= 1'b1;
			end else begin
				m_timer <= m_timer + 1;
				m_tick  <= 1'b0;
			end
			if (m_tick) begin
				m_snap    <= m_running;
				m_running <= '0;
			end else begin
				for (int k = 0; k < pod_pkg::num_lanes; k++) begin
					if (lane_overflow[k]) begin
						m_running.count[k] <= m_running.count[k] + 1;
					end
				end
			end
			m_flushed        <= m_flushed | flush_done;
			m_flush_complete <= &m_flushed;
		end
	end

	////////////////////////////////////////
	// Compare tasks

	task automatic report_mismatch(input string msg);
		$display("Mismatch at %0d ns: %s", $time, msg);
		error_count++;
	endtask

	task automatic check_capture(input pod_pkg::capture_out_t got,
			input pod_pkg::capture_out_t exp);
		check_count++;
		if (got.valid !== exp.valid) begin
			report_mismatch($sformatf("capture_out.valid is %b, expected %b",
				got.valid, exp.valid));
		end
		if (got.overflow !== exp.overflow) begin
			report_mismatch($sformatf("capture_out.overflow is %b, expected %b",
				got.overflow, exp.overflow));
		end
		// Words only matter while valid
		if (exp.valid && got.samples !== exp.samples) begin
			report_mismatch($sformatf("capture_out.samples is %h, expected %h",
				got.samples, exp.samples));
		end
	endtask

	task automatic check_snapshot(input pod_pkg::ovf_snapshot_t got,
			input pod_pkg::ovf_snapshot_t exp);
		check_count++;
		for (int k = 0; k < pod_pkg::num_lanes; k++) begin
			if (got.count[k] !== exp.count[k]) begin
				report_mismatch($sformatf("ovf_snapshot lane %0d is %0d, expected %0d",
					k, got.count[k], exp.count[k]));
			end
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		check_count++;
		if (got !== exp) begin
			report_mismatch($sformatf("%s is %b, expected %b", name, got, exp));
		end
	endtask

	// Outputs are settled by the falling edge
	always @(negedge clk_312p5mhz) begin
		check_capture(capture_out, m_capture);
		check_flag("interval_tick", interval_tick, m_tick);
		check_flag("flush_complete", flush_complete, m_flush_complete);
		check_snapshot(ovf_snapshot, m_snap);
	end

	////////////////////////////////////////
	// Stimulus

	function automatic pod_pkg::pod_legs_t random_legs();
		return {$urandom, $urandom, $urandom, $urandom};
	endfunction

	function automatic pod_pkg::lane_mask_t random_pulses();
		return pod_pkg::lane_mask_t'($urandom & $urandom);
	endfunction

	// One clock of inputs
	// Overflow pulses skip the clock that meets a tick
	task automatic drive_cycle(input logic rst, input logic en,
			input pod_pkg::lane_mask_t ovf, input pod_pkg::lane_mask_t fl);
		pod_pkg::lane_mask_t safe_ovf;
		@(posedge clk_312p5mhz);
		safe_ovf = (m_timer == tb_interval - 1) ? '0 : ovf;
		tb_rst        <= rst;
		pod_legs      <= random_legs();
		capture_en    <= en;
		lane_overflow <= safe_ovf;
		flush_done    <= fl;
	endtask

	task automatic finish_test(input string name, input int errs_before);
		$display("test %s finished with %0d errors", name, error_count - errs_before);
	endtask

	task automatic drive_random_legs();
		int errs_before;
		errs_before = error_count;
		repeat (len_remap) drive_cycle(1'b0, 1'b1, '0, '0);
		finish_test("remap and inversion", errs_before);
	endtask

	task automatic toggle_capture_en();
		int errs_before;
		errs_before = error_count;
		repeat (len_gating) drive_cycle(1'b0, 1'($urandom % 2), '0, '0);
		finish_test("capture gating", errs_before);
	endtask

	task automatic count_overflow_snapshots();
		int errs_before;
		errs_before = error_count;
		repeat (len_snapshot) drive_cycle(1'b0, 1'b1, random_pulses(), '0);
		finish_test("overflow snapshot", errs_before);
	endtask

	task automatic watch_overflow_mask();
		int errs_before;
		int lane;
		pod_pkg::lane_mask_t lane_bit;
		errs_before = error_count;
		lane = int'($urandom % pod_pkg::num_lanes);
		lane_bit = '0;
		lane_bit[lane] = 1'b1;
		// Quiet until early in an interval
		for (int n = 0; n < 2 * tb_interval && m_timer != 8; n++) begin
			drive_cycle(1'b0, 1'b1, '0, '0);
		end
		drive_cycle(1'b0, 1'b1, lane_bit, '0);
		repeat (2) drive_cycle(1'b0, 1'b1, '0, '0);
		@(negedge clk_312p5mhz);
		check_flag("overflow mask after pulse", capture_out.overflow[lane], 1'b1);
		// Past the next tick the mask must be clear again
		repeat (70) drive_cycle(1'b0, 1'b1, '0, '0);
		@(negedge clk_312p5mhz);
		check_flag("overflow mask after tick", capture_out.overflow[lane], 1'b0);
		finish_test("overflow mask", errs_before);
	endtask

	task automatic track_flush_order();
		int order [pod_pkg::num_lanes];
		int errs_before;
		int pick;
		int swap;
		int gap;
		pod_pkg::lane_mask_t lane_bit;
		errs_before = error_count;
		for (int k = 0; k < pod_pkg::num_lanes; k++) begin
			order[k] = k;
		end
		// Shuffle the lane order
		for (int k = pod_pkg::num_lanes - 1; k > 0; k--) begin
			pick = int'($urandom % (k + 1));
			swap = order[k];
			order[k] = order[pick];
			order[pick] = swap;
		end
		for (int k = 0; k < pod_pkg::num_lanes; k++) begin
			lane_bit = '0;
			lane_bit[order[k]] = 1'b1;
			drive_cycle(1'b0, 1'b1, '0, lane_bit);
			if (k < pod_pkg::num_lanes - 1) begin
				gap = int'($urandom % 3);
				repeat (gap) drive_cycle(1'b0, 1'b1, '0, '0);
			end
		end
		drive_cycle(1'b0, 1'b1, '0, '0);
		@(negedge clk_312p5mhz);
		check_flag("flush_complete one clock after last pulse", flush_complete, 1'b0);
		drive_cycle(1'b0, 1'b1, '0, '0);
		@(negedge clk_312p5mhz);
		check_flag("flush_complete two clocks after last pulse", flush_complete, 1'b1);
		repeat (10) drive_cycle(1'b0, 1'b1, '0, '0);
		finish_test("flush tracking", errs_before);
	endtask

	task automatic apply_mid_reset();
		int errs_before;
		errs_before = error_count;
		// Build up some counts first
		repeat (20) drive_cycle(1'b0, 1'b1, random_pulses(), '0);
		repeat (2) drive_cycle(1'b1, 1'b1, '0, '0);
		drive_cycle(1'b0, 1'b1, '0, '0);
		@(negedge clk_312p5mhz);
		check_flag("valid after reset", capture_out.valid, 1'b0);
		check_flag("interval_tick after reset", interval_tick, 1'b0);
		check_flag("flush_complete after reset", flush_complete, 1'b0);
		check_flag("overflow mask after reset", |capture_out.overflow, 1'b0);
		// Snapshots from here on count from zero
		repeat (2 * tb_interval + 4) drive_cycle(1'b0, 1'b1, random_pulses(), '0);
		finish_test("reset state", errs_before);
	endtask

	initial begin
		capture_en    = 1'b0;
		pod_legs      = '0;
		lane_overflow = '0;
		flush_done    = '0;
		first_draw    = $urandom(rng_seed);
		@(negedge por_rst);
		drive_random_legs();
		toggle_capture_en();
		count_overflow_snapshots();
		watch_overflow_mask();
		track_flush_order();
		apply_mid_reset();
		$display("tests: 6, checks: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

	////////////////////////////////////////
	// Watchdog

	initial begin
		#(watchdog_cycles * clk_period_ns);
		$display("Timeout: tests did not finish within %0d clock periods", watchdog_cycles);
		$display("ERRORS FOUND");
		$finish;
	end

endmodule

// ==== pod_datapath.f ====
hdl/pod_pkg.sv
hdl/sample_merge.sv
hdl/overflow_counter.sv
hdl/pod_capture.sv
hdl/pod_datapath.sv
bench/pod_clock_gen.sv
bench/pod_datapath_tb.sv

// ==== Bender.yml ====
package:
  name: pod_datapath

dependencies: {}

sources:
  - hdl/pod_pkg.sv
  - hdl/sample_merge.sv
  - hdl/overflow_counter.sv
  - hdl/pod_capture.sv
  - hdl/pod_datapath.sv
  - target: simulation
    files:
      - bench/pod_clock_gen.sv
      - bench/pod_datapath_tb.sv
